//--- src.f
+incdir+include
rtl/shtp_pkg.sv
rtl/spi_mode3_target.sv
rtl/shtp_cmd_parser.sv
rtl/rv_sample_fifo.sv
rtl/shtp_tx_builder.sv
rtl/host_int_ctrl.sv
rtl/shtp_sensor_hub.sv
tests/shtp_hub_sva.sv
tests/shtp_hub_tb.sv

//--- Bender.yml
package:
  name: shtp_sensor_hub

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/shtp_pkg.sv
      - rtl/spi_mode3_target.sv
      - rtl/shtp_cmd_parser.sv
      - rtl/rv_sample_fifo.sv
      - rtl/shtp_tx_builder.sv
      - rtl/host_int_ctrl.sv
      - rtl/shtp_sensor_hub.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/shtp_hub_sva.sv
      - tests/shtp_hub_tb.sv

//--- tests/shtp_hub_tb.sv
`default_nettype none

`include "shtp_defs.svh"

module shtp_hub_tb
    import shtp_pkg::*;
();

    logic  clk;
    logic  rst_n;
    logic  ps0_wake;
    logic  cs_n;
    logic  sclk;
    logic  mosi;
    logic  miso;
    logic  int_n;
    logic  sample_valid;
    quat_t sample_x;
    quat_t sample_y;
    quat_t sample_z;
    quat_t sample_w;
    logic  sample_credit;

    shtp_byte_t host_tx [32];   // Bytes the host shifts out
    shtp_byte_t host_rx [32];   // Bytes seen on miso
    quat_t      exp_x [$];      // Samples in flight, oldest first
    quat_t      exp_y [$];
    quat_t      exp_z [$];
    quat_t      exp_w [$];
    int         credits_spent = 0;
    int         credits_back = 0;

    shtp_sensor_hub u_dut (
        .clk(clk), .rst_n(rst_n), .ps0_wake(ps0_wake),
        .cs_n(cs_n), .sclk(sclk), .mosi(mosi), .miso(miso), .int_n(int_n),
        .sample_valid(sample_valid),
        .sample_x(sample_x), .sample_y(sample_y),
        .sample_z(sample_z), .sample_w(sample_w),
        .sample_credit(sample_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst_n && sample_credit) credits_back = credits_back + 1;
        if (u_dut.u_sva.assert_errs != 0) begin
            $display("A bound assertion on the hub failed");
            abort_run();
        end
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input shtp_byte_t exp, input shtp_byte_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_len(input string name, input shtp_len_t exp, input shtp_len_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_quat(input string name, input quat_t exp, input quat_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    function automatic int credits_held();
        return `HUB_FIFO_DEPTH - credits_spent + credits_back;
    endfunction

    task automatic wait_int_low(input string name, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (int_n !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("%s: int_n did not fall within %0d cycles", name, limit);
                abort_run();
            end
        end
    endtask

    // Stops early once every credit is home, the caller checks the count
    task automatic wait_credits(input int limit);
        int n;
        n = 0;
        while (credits_held() != `HUB_FIFO_DEPTH && n < limit) begin
            @(negedge clk);
            n++;
        end
    endtask

    // Mode 3 host, eight clk per half bit, MSB first
    task automatic transfer(input int count);
        @(posedge clk);
        cs_n <= 1'b0;
        repeat (8) @(posedge clk);
        for (int b = 0; b < count; b++) begin
            for (int i = 7; i >= 0; i--) begin
                sclk <= 1'b0;                  // Launch edge
                mosi <= host_tx[b][i];
                repeat (7) @(posedge clk);
                @(negedge clk);
                host_rx[b][i] = miso;          // Settled long before the rise
                @(posedge clk);
                sclk <= 1'b1;                  // Sample edge
                repeat (8) @(posedge clk);
            end
        end
        @(negedge clk);
        if (int_n !== 1'b1) begin
            $display("int_n stayed low while cs_n was low");
            abort_run();
        end
        @(posedge clk);
        cs_n <= 1'b1;
        mosi <= 1'b0;
        repeat (8) @(posedge clk);             // Covers cs_end and the credit pulse
    endtask

    task automatic read_response(input int count);
        for (int i = 0; i < count; i++) host_tx[i] = 8'h00;
        transfer(count);
    endtask

    task automatic push_sample();
        quat_t q [4];
        for (int i = 0; i < 4; i++) q[i] = quat_t'($urandom);
        if (credits_held() <= 0) begin
            $display("Producer tried to send a sample without a credit");
            abort_run();
        end
        @(posedge clk);
        sample_valid <= 1'b1;
        sample_x     <= q[0];
        sample_y     <= q[1];
        sample_z     <= q[2];
        sample_w     <= q[3];
        credits_spent++;
        exp_x.push_back(q[0]);
        exp_y.push_back(q[1]);
        exp_z.push_back(q[2]);
        exp_w.push_back(q[3]);
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    // Rotation vector layout, count below 18 checks only the header part
    task automatic check_report(input string name, input int count);
        shtp_byte_t hdr [8];
        hdr = '{8'd18, 8'h00, `SHTP_CH_REPORTS, 8'h00, `SHTP_RPT_ROT_VECTOR,
                8'h00, 8'h00, 8'h00};
        for (int i = 0; i < 8 && i < count; i++) begin
            check_byte($sformatf("%s byte %0d", name, i), hdr[i], host_rx[i]);
        end
        if (count == 18) begin
            check_quat({name, " x"}, exp_x[0], {host_rx[9], host_rx[8]});   // Little-endian
            check_quat({name, " y"}, exp_y[0], {host_rx[11], host_rx[10]});
            check_quat({name, " z"}, exp_z[0], {host_rx[13], host_rx[12]});
            check_quat({name, " w"}, exp_w[0], {host_rx[15], host_rx[14]});
            check_byte({name, " byte 16"}, 8'h00, host_rx[16]);
            check_byte({name, " byte 17"}, 8'h00, host_rx[17]);
            exp_x.delete(0);
            exp_y.delete(0);
            exp_z.delete(0);
            exp_w.delete(0);
        end
    endtask

    task automatic read_product_id(input string name);
        shtp_byte_t exp [9];
        exp = '{8'h09, 8'h00, `SHTP_CH_COMMAND, 8'h00, `SHTP_CMD_PROD_ID_RSP,
                8'h00, 8'h00, 8'hA0, 8'h02};
        host_tx[0] = 8'h05;
        host_tx[1] = 8'h00;
        host_tx[2] = `SHTP_CH_COMMAND;
        host_tx[3] = shtp_byte_t'($urandom);
        host_tx[4] = `SHTP_CMD_PROD_ID_REQ;
        transfer(5);
        wait_int_low(name, 20);
        read_response(9);
        for (int i = 0; i < 9; i++) begin
            check_byte($sformatf("%s byte %0d", name, i), exp[i], host_rx[i]);
        end
    endtask

    task automatic boot_and_release();
        for (int i = 0; i <= `HUB_BOOT_CYCLES; i++) begin
            @(negedge clk);
            if (int_n !== 1'b1) begin
                $display("boot: int_n fell before the boot delay ended");
                abort_run();
            end
        end
        wait_int_low("boot", 1);               // Falls one cycle after the count
        read_response(4);                      // Dummy read, nothing queued
        for (int i = 0; i < 4; i++) begin
            check_byte($sformatf("boot byte %0d", i), 8'h00, host_rx[i]);
        end
        @(negedge clk);
        if (int_n !== 1'b1) begin
            $display("boot: int_n fell again with nothing pending");
            abort_run();
        end
    endtask

    task automatic product_id_exchange();
        read_product_id("product id");
        @(negedge clk);
        if (int_n !== 1'b1) begin
            $display("product id: int_n not released after the read");
            abort_run();
        end
    endtask

    task automatic set_feature_ack();
        shtp_byte_t seq;
        seq = shtp_byte_t'($urandom);
        host_tx[0] = 8'h06;
        host_tx[1] = 8'h00;
        host_tx[2] = `SHTP_CH_CONTROL;
        host_tx[3] = seq;
        host_tx[4] = `SHTP_CMD_SET_FEATURE;
        host_tx[5] = `SHTP_RPT_ROT_VECTOR;    // Enables the report stream
        transfer(6);
        wait_int_low("set feature", 20);
        read_response(5);
        check_byte("set feature len", 8'h05, host_rx[0]);
        check_byte("set feature len msb", 8'h00, host_rx[1]);
        check_byte("set feature channel", `SHTP_CH_CONTROL, host_rx[2]);
        check_byte("set feature seq", seq, host_rx[3]);
        check_byte("set feature code", `SHTP_CMD_FEATURE_RSP, host_rx[4]);
    endtask

    task automatic report_stream();
        repeat (4) push_sample();
        for (int r = 0; r < 4; r++) begin
            wait_int_low($sformatf("report %0d", r), 40);
            read_response(18);
            check_report($sformatf("report %0d", r), 18);
        end
        wait_credits(40);
        check_len("reports credits", `HUB_FIFO_DEPTH, shtp_len_t'(credits_held()));
    endtask

    task automatic command_priority();
        push_sample();
        push_sample();
        wait_int_low("ordering", 20);          // A report is already waiting
        read_product_id("ordering product id");
        check_len("ordering credits", `HUB_FIFO_DEPTH - 2, shtp_len_t'(credits_held()));
        for (int r = 0; r < 2; r++) begin
            wait_int_low($sformatf("ordering report %0d", r), 40);
            read_response(18);
            check_report($sformatf("ordering report %0d", r), 18);
        end
        wait_credits(40);
        check_len("ordering final credits", `HUB_FIFO_DEPTH, shtp_len_t'(credits_held()));
    endtask

    task automatic aborted_report_read();
        push_sample();
        wait_int_low("abort", 20);
        read_response(6);                      // Host gives up early
        check_report("abort partial", 6);
        check_len("abort early credits", `HUB_FIFO_DEPTH - 1, shtp_len_t'(credits_held()));
        wait_int_low("abort reread", 20);
        read_response(18);
        check_report("abort reread", 18);
        wait_credits(40);
        check_len("abort final credits", `HUB_FIFO_DEPTH, shtp_len_t'(credits_held()));
    endtask

    initial begin
        void'($urandom(32'h6b1295a1));
        rst_n        = 1'b0;
        ps0_wake     = 1'b1;                   // PS0 idle high
        cs_n         = 1'b1;
        sclk         = 1'b1;                   // Mode 3 idle
        mosi         = 1'b0;
        sample_valid = 1'b0;
        sample_x     = '0;
        sample_y     = '0;
        sample_z     = '0;
        sample_w     = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        boot_and_release();
        product_id_exchange();
        set_feature_ack();
        report_stream();
        command_priority();
        aborted_report_read();
        repeat (10) @(posedge clk);
        if (u_dut.u_sva.assert_errs != 0) begin
            $display("Bound assertions reported errors");
            abort_run();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/shtp_hub_sva.sv
`default_nettype none

module shtp_hub_sva (
    input wire clk,
    input wire rst_n,
    input wire cs_n,
    input wire miso,
    input wire int_n,
    input wire sample_credit
);

    int assert_errs = 0;   // Failed assertion count

    // Credit returns within three cycles of the cs_n rise
    a_credit_after_deselect: assert property (@(posedge clk) disable iff (!rst_n)
        sample_credit |-> $past(cs_n)
                          && !($past(cs_n, 2) && $past(cs_n, 3) && $past(cs_n, 4)))
        else begin
            assert_errs++;
            $error("credit not within three cycles of cs_n rising");
        end

    // Select releases the interrupt within four cycles
    a_int_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cs_n) |-> ##[1:4] int_n)
        else begin
            assert_errs++;
            $error("int_n not released after cs_n fell");
        end

    a_miso_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cs_n [*4] |-> !miso)                   // Sync plus clear latency
        else begin
            assert_errs++;
            $error("miso not low while deselected");
        end

endmodule

bind shtp_sensor_hub shtp_hub_sva u_sva (
    .clk(clk), .rst_n(rst_n), .cs_n(cs_n), .miso(miso), .int_n(int_n),
    .sample_credit(sample_credit)
);

`default_nettype wire

//--- rtl/shtp_sensor_hub.sv
`default_nettype none

module shtp_sensor_hub
    import shtp_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        ps0_wake,
    input  wire        cs_n,
    input  wire        sclk,
    input  wire        mosi,
    output logic       miso,
    output logic       int_n,
    input  wire        sample_valid,
    input  wire quat_t sample_x,
    input  wire quat_t sample_y,
    input  wire quat_t sample_z,
    input  wire quat_t sample_w,
    output logic       sample_credit
);

    shtp_byte_t tx_data;
    shtp_byte_t rx_byte;
    shtp_byte_t rx_seq;
    shtp_len_t  tx_index;
    rsp_kind_t  rsp_kind;
    quat_t      head_x;
    quat_t      head_y;
    quat_t      head_z;
    quat_t      head_w;
    logic       rx_valid;
    logic       cs_start;
    logic       cs_end;
    logic       tx_req;
    logic       rsp_queue;
    logic       feature_on;
    logic       empty;
    logic       pending;
    logic       pop;

    spi_mode3_target u_spi (
        .clk(clk), .rst_n(rst_n),
        .cs_n(cs_n), .sclk(sclk), .mosi(mosi), .tx_data(tx_data),
        .miso(miso), .rx_valid(rx_valid), .rx_byte(rx_byte),
        .cs_start(cs_start), .cs_end(cs_end),
        .tx_req(tx_req), .tx_index(tx_index)
    );

    shtp_cmd_parser u_parser (
        .clk(clk), .rst_n(rst_n),
        .rx_valid(rx_valid), .rx_byte(rx_byte),
        .cs_start(cs_start), .cs_end(cs_end),
        .rsp_queue(rsp_queue), .rsp_kind(rsp_kind),
        .rx_seq(rx_seq), .feature_on(feature_on)
    );

    rv_sample_fifo u_fifo (
        .clk(clk), .rst_n(rst_n),
        .sample_valid(sample_valid),
        .sample_x(sample_x), .sample_y(sample_y),
        .sample_z(sample_z), .sample_w(sample_w),
        .pop(pop), .empty(empty),
        .head_x(head_x), .head_y(head_y), .head_z(head_z), .head_w(head_w),
        .sample_credit(sample_credit)
    );

    shtp_tx_builder u_builder (
        .clk(clk), .rst_n(rst_n),
        .rsp_queue(rsp_queue), .rsp_kind(rsp_kind), .rx_seq(rx_seq),
        .feature_on(feature_on), .empty(empty),
        .head_x(head_x), .head_y(head_y), .head_z(head_z), .head_w(head_w),
        .tx_req(tx_req), .tx_index(tx_index), .cs_end(cs_end),
        .tx_data(tx_data), .pending(pending), .rsp_done(), .pop(pop)
    );

    host_int_ctrl u_int (
        .clk(clk), .rst_n(rst_n), .ps0_wake(ps0_wake),
        .cs_start(cs_start), .cs_end(cs_end), .pending(pending),
        .int_n(int_n)
    );

endmodule

`default_nettype wire

//--- rtl/host_int_ctrl.sv
`default_nettype none

`include "shtp_defs.svh"

module host_int_ctrl
    import shtp_pkg::*;
(
    input  wire clk,
    input  wire rst_n,
    input  wire ps0_wake,
    input  wire cs_start,
    input  wire cs_end,
    input  wire pending,
    output logic int_n
);

    localparam int CNT_W = $clog2(`HUB_BOOT_CYCLES + 1);

    int_state_t       state;
    logic [CNT_W-1:0] boot_cnt;
    logic [1:0]       ps0_sync;
    logic             ps0_prev;
    logic             ps0_fall;

    // PS0 idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ps0_sync <= 2'b11;
            ps0_prev <= 1'b1;
        end else begin
            ps0_sync <= {ps0_sync[0], ps0_wake};
            ps0_prev <= ps0_sync[1];
        end
    end

    assign ps0_fall = ps0_prev & ~ps0_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= INT_BOOT;
            boot_cnt <= '0;
        end else begin
            case (state)
                INT_BOOT: begin
                    if (ps0_fall || boot_cnt == CNT_W'(`HUB_BOOT_CYCLES)) begin
                        state <= INT_PENDING;     // Ready announcement
                    end else begin
                        boot_cnt <= boot_cnt + 1'b1;
                    end
                end
                INT_IDLE: begin
                    if (cs_start) state <= INT_SERVING;
                    else if (pending) state <= INT_PENDING;
                end
                INT_PENDING: if (cs_start) state <= INT_SERVING;   // Release on select
                INT_SERVING: if (cs_end) state <= INT_IDLE;        // Pending rechecked in idle
                default: state <= INT_IDLE;
            endcase
        end
    end

    assign int_n = (state != INT_PENDING);

endmodule

`default_nettype wire

//--- rtl/shtp_tx_builder.sv
`default_nettype none

`include "shtp_defs.svh"

module shtp_tx_builder
    import shtp_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             rsp_queue,
    input  wire rsp_kind_t  rsp_kind,
    input  wire shtp_byte_t rx_seq,
    input  wire             feature_on,
    input  wire             empty,
    input  wire quat_t      head_x,
    input  wire quat_t      head_y,
    input  wire quat_t      head_z,
    input  wire quat_t      head_w,
    input  wire             tx_req,
    input  wire shtp_len_t  tx_index,
    input  wire             cs_end,
    output shtp_byte_t      tx_data,
    output logic            pending,
    output logic            rsp_done,
    output logic            pop
);

    localparam logic [23:0] PID = `SHTP_PRODUCT_ID;

    rsp_kind_t  kind;
    shtp_byte_t seq_q;
    shtp_len_t  served;      // Bytes clocked out so far in this transaction
    shtp_len_t  rsp_len;
    logic       from_zero;   // Current transaction began at byte 0 of this response
    logic       done;

    always_comb begin
        case (kind)
            RSP_PROD_ID:     rsp_len = 16'd9;
            RSP_FEATURE_ACK: rsp_len = 16'd5;
            RSP_ROT_VECTOR:  rsp_len = 16'd18;
            default:         rsp_len = 16'd0;
        endcase
    end

    assign pending  = (kind != RSP_NONE);
    assign done     = pending && from_zero && (served >= rsp_len);
    assign rsp_done = cs_end & done;
    assign pop      = rsp_done & (kind == RSP_ROT_VECTOR);

    // Commands override a report still waiting, the sample stays queued
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kind      <= RSP_NONE;
            served    <= '0;
            from_zero <= 1'b0;
        end else if (rsp_queue) begin
            kind      <= rsp_kind;
            served    <= '0;
            from_zero <= 1'b0;
        end else if (rsp_done) begin
            kind      <= RSP_NONE;
            from_zero <= 1'b0;
        end else if (!pending && feature_on && !empty) begin
            kind      <= RSP_ROT_VECTOR;   // Next report from the FIFO head
            served    <= '0;
            from_zero <= 1'b0;
        end else if (tx_req) begin
            served <= tx_index;
            if (tx_index == 16'd0) from_zero <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_queue) seq_q <= rx_seq;
    end

    // Byte map, zeros for reserved fields and past the end
    always_comb begin
        tx_data = 8'h00;
        if (tx_index == 16'd0) begin
            tx_data = rsp_len[7:0];          // Length LSB
        end else if (tx_index == 16'd1) begin
            tx_data = rsp_len[15:8];
        end else begin
            case (kind)
                RSP_PROD_ID: begin
                    case (tx_index)
                        16'd2:   tx_data = `SHTP_CH_COMMAND;
                        16'd4:   tx_data = `SHTP_CMD_PROD_ID_RSP;
                        16'd6:   tx_data = PID[23:16];   // BNO085 byte order
                        16'd7:   tx_data = PID[7:0];
                        16'd8:   tx_data = PID[15:8];
                        default: tx_data = 8'h00;
                    endcase
                end
                RSP_FEATURE_ACK: begin
                    case (tx_index)
                        16'd2:   tx_data = `SHTP_CH_CONTROL;
                        16'd3:   tx_data = seq_q;        // Echo of host sequence
                        16'd4:   tx_data = `SHTP_CMD_FEATURE_RSP;
                        default: tx_data = 8'h00;
                    endcase
                end
                RSP_ROT_VECTOR: begin
                    case (tx_index)
                        16'd2:   tx_data = `SHTP_CH_REPORTS;
                        16'd4:   tx_data = `SHTP_RPT_ROT_VECTOR;
                        16'd8:   tx_data = head_x[7:0];  // Quaternions little-endian
                        16'd9:   tx_data = head_x[15:8];
                        16'd10:  tx_data = head_y[7:0];
                        16'd11:  tx_data = head_y[15:8];
                        16'd12:  tx_data = head_z[7:0];
                        16'd13:  tx_data = head_z[15:8];
                        16'd14:  tx_data = head_w[7:0];
                        16'd15:  tx_data = head_w[15:8];
                        default: tx_data = 8'h00;        // Seq, status, delay, accuracy
                    endcase
                end
                default: tx_data = 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_sample_fifo.sv
`default_nettype none

`include "shtp_defs.svh"

module rv_sample_fifo
    import shtp_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        sample_valid,
    input  wire quat_t sample_x,
    input  wire quat_t sample_y,
    input  wire quat_t sample_z,
    input  wire quat_t sample_w,
    input  wire        pop,
    output logic       empty,
    output quat_t      head_x,
    output quat_t      head_y,
    output quat_t      head_z,
    output quat_t      head_w,
    output logic       sample_credit
);

    localparam int ADDR_W = $clog2(`HUB_FIFO_DEPTH);

    quat_t     mem_x [`HUB_FIFO_DEPTH];
    quat_t     mem_y [`HUB_FIFO_DEPTH];
    quat_t     mem_z [`HUB_FIFO_DEPTH];
    quat_t     mem_w [`HUB_FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;

    // Producer credits keep pushes off a full FIFO
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            sample_credit <= 1'b0;
        end else begin
            if (sample_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            sample_credit <= pop;   // One credit back per drained entry
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            mem_x[wr_ptr[ADDR_W-1:0]] <= sample_x;
            mem_y[wr_ptr[ADDR_W-1:0]] <= sample_y;
            mem_z[wr_ptr[ADDR_W-1:0]] <= sample_z;
            mem_w[wr_ptr[ADDR_W-1:0]] <= sample_w;
        end
    end

    assign empty  = (wr_ptr == rd_ptr);   // Wrap bits equal too
    assign head_x = mem_x[rd_ptr[ADDR_W-1:0]];
    assign head_y = mem_y[rd_ptr[ADDR_W-1:0]];
    assign head_z = mem_z[rd_ptr[ADDR_W-1:0]];
    assign head_w = mem_w[rd_ptr[ADDR_W-1:0]];

endmodule

`default_nettype wire

//--- rtl/shtp_cmd_parser.sv
`default_nettype none

`include "shtp_defs.svh"

module shtp_cmd_parser
    import shtp_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             rx_valid,
    input  wire shtp_byte_t rx_byte,
    input  wire             cs_start,
    input  wire             cs_end,
    output logic            rsp_queue,
    output rsp_kind_t       rsp_kind,
    output shtp_byte_t      rx_seq,
    output logic            feature_on
);

    shtp_len_t  byte_cnt;
    shtp_byte_t chan;
    shtp_byte_t cmd;
    shtp_byte_t rid;
    logic       is_prod_req;
    logic       is_set_feat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
        end else if (cs_start) begin
            byte_cnt <= '0;
        end else if (rx_valid) begin
            byte_cnt <= byte_cnt + 16'd1;
        end
    end

    // Header fields, length bytes 0 and 1 are not checked
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (byte_cnt)
                16'd2:   chan   <= rx_byte;
                16'd3:   rx_seq <= rx_byte;
                16'd4:   cmd    <= rx_byte;   // First payload byte
                16'd5:   rid    <= rx_byte;   // Set Feature report ID
                default: ;
            endcase
        end
    end

    // Byte count guards against fields left from an earlier write
    assign is_prod_req = (byte_cnt > 16'd4) && (chan == `SHTP_CH_COMMAND)
                         && (cmd == `SHTP_CMD_PROD_ID_REQ);
    assign is_set_feat = (byte_cnt > 16'd4) && (chan == `SHTP_CH_CONTROL)
                         && (cmd == `SHTP_CMD_SET_FEATURE);

    assign rsp_queue = cs_end & (is_prod_req | is_set_feat);
    assign rsp_kind  = is_prod_req ? RSP_PROD_ID :
                       is_set_feat ? RSP_FEATURE_ACK : RSP_NONE;

    // Sticky once the rotation vector is asked for
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feature_on <= 1'b0;
        end else if (cs_end && is_set_feat && byte_cnt > 16'd5
                     && rid == `SHTP_RPT_ROT_VECTOR) begin
            feature_on <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/spi_mode3_target.sv
`default_nettype none

module spi_mode3_target
    import shtp_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             cs_n,
    input  wire             sclk,
    input  wire             mosi,
    input  wire shtp_byte_t tx_data,
    output logic            miso,
    output logic            rx_valid,
    output shtp_byte_t      rx_byte,
    output logic            cs_start,
    output logic            cs_end,
    output logic            tx_req,
    output shtp_len_t       tx_index
);

    logic [1:0] cs_sync;
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic       cs_prev;
    logic       sclk_prev;
    logic       active;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_cnt;
    shtp_byte_t rx_shift;
    shtp_byte_t tx_shift;
    shtp_len_t  byte_idx;

    // Two-flop synchronizers, pins idle as Mode 3 with cs_n high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_sync   <= 2'b11;
            sclk_sync <= 2'b11;
            mosi_sync <= 2'b00;
            cs_prev   <= 1'b1;
            sclk_prev <= 1'b1;
        end else begin
            cs_sync   <= {cs_sync[0], cs_n};
            sclk_sync <= {sclk_sync[0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            cs_prev   <= cs_sync[1];
            sclk_prev <= sclk_sync[1];
        end
    end

    assign active    = ~cs_sync[1];
    assign cs_start  = cs_prev & ~cs_sync[1];
    assign cs_end    = ~cs_prev & cs_sync[1];
    assign sclk_rise = active & ~sclk_prev & sclk_sync[1];   // Sample edge
    assign sclk_fall = active & sclk_prev & ~sclk_sync[1];   // Launch edge
    assign tx_index  = byte_idx;

    // Bit and byte counting, strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= 3'd0;
            byte_idx <= '0;
            rx_valid <= 1'b0;
            tx_req   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            tx_req   <= 1'b0;
            if (cs_start) begin
                bit_cnt  <= 3'd0;
                byte_idx <= '0;
                tx_req   <= 1'b1;       // Fetch byte 0 before the first launch edge
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_valid <= 1'b1;
                    byte_idx <= byte_idx + 16'd1;
                    tx_req   <= 1'b1;   // Next byte, index already advanced
                end
            end
        end
    end

    // Shift registers, MSB first both ways
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_sync[1]};
        end
        if (sclk_rise && bit_cnt == 3'd7) begin
            rx_byte <= {rx_shift[6:0], mosi_sync[1]};
        end
        if (tx_req) begin
            tx_shift <= tx_data;
        end else if (sclk_fall) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miso <= 1'b0;
        end else if (cs_end) begin
            miso <= 1'b0;               // Back to idle low
        end else if (sclk_fall) begin
            miso <= tx_shift[7];
        end
    end

endmodule

`default_nettype wire

//--- rtl/shtp_pkg.sv
`default_nettype none

`include "shtp_defs.svh"

package shtp_pkg;

    typedef logic [7:0] shtp_byte_t;      // One SPI / SHTP byte
    typedef logic [15:0] shtp_len_t;      // Length field or byte index
    typedef logic signed [15:0] quat_t;   // Quaternion component, Q14

    // Two address bits plus wrap bit for a depth of four
    typedef logic [$clog2(`HUB_FIFO_DEPTH):0] fifo_ptr_t;

    // What the builder is holding for the host
    typedef enum logic [1:0] {
        RSP_NONE,
        RSP_PROD_ID,
        RSP_FEATURE_ACK,
        RSP_ROT_VECTOR
    } rsp_kind_t;

    // Interrupt line states
    typedef enum logic [1:0] {
        INT_BOOT,      // Counting down after reset
        INT_IDLE,      // Nothing to announce
        INT_PENDING,   // int_n held low
        INT_SERVING    // Host has cs_n low
    } int_state_t;

endpackage

`default_nettype wire

//--- include/shtp_defs.svh
`ifndef SHTP_DEFS_SVH
`define SHTP_DEFS_SVH

// SHTP channel numbers
`define SHTP_CH_COMMAND       8'h01
`define SHTP_CH_CONTROL       8'h02
`define SHTP_CH_REPORTS       8'h05

// Command and response codes
`define SHTP_CMD_PROD_ID_REQ  8'hF9
`define SHTP_CMD_PROD_ID_RSP  8'hF1
`define SHTP_CMD_SET_FEATURE  8'hFD
`define SHTP_CMD_FEATURE_RSP  8'hFE

`define SHTP_RPT_ROT_VECTOR   8'h05   // Rotation vector report ID
`define SHTP_PRODUCT_ID       24'h0002A0

// Hub sizing
`define HUB_BOOT_CYCLES       64      // Cycles from reset release to ready
`define HUB_FIFO_DEPTH        4       // Power of two, also the producer's credits

`endif
